/* Bender.yml */
package:
  name: mips_pipeline_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/mips_ctrl_pkg.sv
      - source/instr_decoder.sv
      - source/stage_pipe.sv
      - source/id_control.sv
      - source/hazard_unit.sv
      - source/pipeline_controller.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/controller_checker.sv
      - tests/controller_tb.sv

/* source/hazard_unit.sv */
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module hazard_unit (
    input  mips_ctrl_pkg::instr_info_t id_info,
    input  mips_ctrl_pkg::instr_info_t ex_info,
    input  mips_ctrl_pkg::instr_info_t me_info,
    input  mips_ctrl_pkg::instr_info_t wb_info,
    output logic                       stall,
    output mips_ctrl_pkg::fwd_sel_t    rs_fwd,
    output mips_ctrl_pkg::fwd_sel_t    rt_fwd,
    output mips_ctrl_pkg::fwd_sel_t    hi_fwd,
    output mips_ctrl_pkg::fwd_sel_t    lo_fwd
);
    import mips_ctrl_pkg::*;

    instr_info_t src [3]; // 0 ex, 1 me, 2 wb
    logic [2:0]  rs_hit;
    logic [2:0]  rt_hit;
    logic [2:0]  late;
    logic [2:0]  hi_hit;
    logic [2:0]  lo_hit;

    // older stage writes a register the id word reads, r0 excluded
    function automatic logic gpr_hit(input instr_info_t s, input logic rd_en,
                                     input logic [`REG_IDX_W-1:0] idx);
        return rd_en && s.writes_gpr && (s.dest_idx != '0) && (s.dest_idx == idx);
    endfunction

    // nearest stage wins
    function automatic fwd_sel_t pick(input logic [2:0] hit);
        return hit[0] ? FWD_FROM_EX : hit[1] ? FWD_FROM_ME : hit[2] ? FWD_FROM_WB : FWD_NONE;
    endfunction

    assign src[0] = ex_info;
    assign src[1] = me_info;
    assign src[2] = wb_info;

    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            rs_hit[i] = gpr_hit(src[i], id_info.reads_rs, id_info.rs_idx);
            rt_hit[i] = gpr_hit(src[i], id_info.reads_rt, id_info.rt_idx);
            late[i]   = src[i].late_result;
            hi_hit[i] = id_info.reads_hi & src[i].writes_hilo;
            lo_hit[i] = id_info.reads_lo & src[i].writes_hilo;
        end
    end

    // lw/jal results wait until they leave wb
    assign stall = |(late & (rs_hit | rt_hit));

    assign rs_fwd = pick(rs_hit & ~late);
    assign rt_fwd = pick(rt_hit & ~late);
    assign hi_fwd = pick(hi_hit);
    assign lo_fwd = pick(lo_hit);

endmodule

/* source/id_control.sv */
`timescale 1ns/1ps

module id_control (
    input  mips_ctrl_pkg::instr_info_t id_info,
    input  logic                       equal,
    input  logic                       stall,
    output logic                       rf_w,
    output mips_ctrl_pkg::alu_op_t     aluc,
    output mips_ctrl_pkg::pc_sel_t     pc_sel,
    output mips_ctrl_pkg::alua_sel_t   alua_sel,
    output mips_ctrl_pkg::alub_sel_t   alub_sel,
    output logic                       rd_from_mem,
    output mips_ctrl_pkg::rdc_sel_t    rdc_sel,
    output logic                       cs,
    output logic                       dm_r,
    output logic                       dm_w,
    output logic                       hilo_w
);
    import mips_ctrl_pkg::*;

    logic [I_NUM-1:0] c;

    assign c = id_info.cls;

    always_comb
    begin
        case (1'b1)
            c[I_ADD], c[I_ADDI], c[I_LW], c[I_SW]: aluc = ALU_ADD;
            c[I_SUB]:                aluc = ALU_SUB;
            c[I_SUBU]:               aluc = ALU_SUBU;
            c[I_AND], c[I_ANDI]:     aluc = ALU_AND;
            c[I_OR], c[I_ORI]:       aluc = ALU_OR;
            c[I_XOR], c[I_XORI]:     aluc = ALU_XOR;
            c[I_NOR]:                aluc = ALU_NOR;
            c[I_LUI]:                aluc = ALU_LUI;
            c[I_SLT], c[I_SLTI]:     aluc = ALU_SLT;
            c[I_SLTU], c[I_SLTIU]:   aluc = ALU_SLTU;
            c[I_SRA], c[I_SRAV]:     aluc = ALU_SRA;
            c[I_SRL], c[I_SRLV]:     aluc = ALU_SRL;
            c[I_SLL], c[I_SLLV]:     aluc = ALU_SLL;
            c[I_MFHI], c[I_MFLO]:    aluc = ALU_PASS;
            default:                 aluc = ALU_ADDU; // addu, addiu and the rest
        endcase

        case (1'b1)
            c[I_SLL], c[I_SRL], c[I_SRA]: alua_sel = ALUA_SHAMT;
            c[I_JAL]:  alua_sel = ALUA_NPC; // link value through the alu
            c[I_MFHI]: alua_sel = ALUA_HI;
            c[I_MFLO]: alua_sel = ALUA_LO;
            default:   alua_sel = ALUA_RS;
        endcase

        case (1'b1)
            c[I_ADDI], c[I_ADDIU], c[I_SLTI], c[I_SLTIU], c[I_LW], c[I_SW]:
                alub_sel = ALUB_SEXT_IMM;
            c[I_ANDI], c[I_ORI], c[I_XORI], c[I_LUI]:
                alub_sel = ALUB_ZEXT_IMM;
            c[I_JAL]:
                alub_sel = ALUB_ZERO;
            default:
                alub_sel = ALUB_RT;
        endcase

        case (1'b1)
            c[I_JAL]: rdc_sel = RDC_LINK;
            c[I_ADDI], c[I_ADDIU], c[I_ANDI], c[I_ORI], c[I_XORI], c[I_LUI],
            c[I_SLTI], c[I_SLTIU], c[I_LW]:
                rdc_sel = RDC_RT;
            default:  rdc_sel = RDC_RD;
        endcase

        if ((c[I_BEQ] & equal) | (c[I_BNE] & ~equal))
            pc_sel = PC_BRANCH;
        else if (c[I_J] | c[I_JAL])
            pc_sel = PC_JUMP;
        else if (c[I_JR])
            pc_sel = PC_JREG;
        else
            pc_sel = PC_SEQ;
    end

    assign rd_from_mem = c[I_LW];

    // held decode slot acts as a bubble
    assign rf_w   = id_info.writes_gpr & ~stall;
    assign cs     = (c[I_LW] | c[I_SW]) & ~stall;
    assign dm_r   = c[I_LW] & ~stall;
    assign dm_w   = c[I_SW] & ~stall;
    assign hilo_w = id_info.writes_hilo & ~stall;

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module instr_decoder (
    input  logic [`INSTR_W-1:0]        instr,
    output mips_ctrl_pkg::instr_info_t info
);
    import mips_ctrl_pkg::*;

    logic [5:0]            op;
    logic [5:0]            func;
    logic [`REG_IDX_W-1:0] rs;
    logic [`REG_IDX_W-1:0] rt;
    logic [`REG_IDX_W-1:0] rd;
    logic [I_NUM-1:0]      c;
    logic                  alu_rrr;
    logic                  shift_imm;
    logic                  imm_alu;
    logic                  wr_rd;
    logic                  wr_rt;

    assign op   = instr[`F_OP];
    assign func = instr[`F_FUNC];
    assign rs   = instr[`F_RS];
    assign rt   = instr[`F_RT];
    assign rd   = instr[`F_RD];

    always_comb
    begin
        c = '0;
        if (instr != `NOP_WORD) // zero word would otherwise be sll
        begin
            case (op)
                `OP_RTYPE:
                    case (func)
                        `FN_ADD:  c[I_ADD]  = 1'b1;
                        `FN_ADDU: c[I_ADDU] = 1'b1;
                        `FN_SUB:  c[I_SUB]  = 1'b1;
                        `FN_SUBU: c[I_SUBU] = 1'b1;
                        `FN_AND:  c[I_AND]  = 1'b1;
                        `FN_OR:   c[I_OR]   = 1'b1;
                        `FN_XOR:  c[I_XOR]  = 1'b1;
                        `FN_NOR:  c[I_NOR]  = 1'b1;
                        `FN_SLT:  c[I_SLT]  = 1'b1;
                        `FN_SLTU: c[I_SLTU] = 1'b1;
                        `FN_SLL:  c[I_SLL]  = 1'b1;
                        `FN_SRL:  c[I_SRL]  = 1'b1;
                        `FN_SRA:  c[I_SRA]  = 1'b1;
                        `FN_SLLV: c[I_SLLV] = 1'b1;
                        `FN_SRLV: c[I_SRLV] = 1'b1;
                        `FN_SRAV: c[I_SRAV] = 1'b1;
                        `FN_JR:   c[I_JR]   = 1'b1;
                        `FN_MULT: c[I_MULT] = 1'b1;
                        `FN_MFHI: c[I_MFHI] = 1'b1;
                        `FN_MFLO: c[I_MFLO] = 1'b1;
                        default:  c = '0;
                    endcase
                `OP_ADDI:  c[I_ADDI]  = 1'b1;
                `OP_ADDIU: c[I_ADDIU] = 1'b1;
                `OP_ANDI:  c[I_ANDI]  = 1'b1;
                `OP_ORI:   c[I_ORI]   = 1'b1;
                `OP_XORI:  c[I_XORI]  = 1'b1;
                `OP_LUI:   c[I_LUI]   = 1'b1;
                `OP_SLTI:  c[I_SLTI]  = 1'b1;
                `OP_SLTIU: c[I_SLTIU] = 1'b1;
                `OP_LW:    c[I_LW]    = 1'b1;
                `OP_SW:    c[I_SW]    = 1'b1;
                `OP_BEQ:   c[I_BEQ]   = 1'b1;
                `OP_BNE:   c[I_BNE]   = 1'b1;
                `OP_J:     c[I_J]     = 1'b1;
                `OP_JAL:   c[I_JAL]   = 1'b1;
                default:   c = '0;
            endcase
        end
    end

    // three-register ops read rs and rt, write rd
    assign alu_rrr = c[I_ADD] | c[I_ADDU] | c[I_SUB] | c[I_SUBU] | c[I_AND] | c[I_OR]
                   | c[I_XOR] | c[I_NOR] | c[I_SLT] | c[I_SLTU] | c[I_SLLV] | c[I_SRLV]
                   | c[I_SRAV];
    assign shift_imm = c[I_SLL] | c[I_SRL] | c[I_SRA];
    assign imm_alu   = c[I_ADDI] | c[I_ADDIU] | c[I_ANDI] | c[I_ORI] | c[I_XORI]
                     | c[I_SLTI] | c[I_SLTIU];
    assign wr_rd = alu_rrr | shift_imm | c[I_MFHI] | c[I_MFLO];
    assign wr_rt = imm_alu | c[I_LUI] | c[I_LW];

    always_comb
    begin
        info.cls         = c;
        info.reads_rs    = alu_rrr | imm_alu | c[I_LW] | c[I_SW] | c[I_BEQ] | c[I_BNE]
                         | c[I_JR] | c[I_MULT];
        info.reads_rt    = alu_rrr | shift_imm | c[I_SW] | c[I_BEQ] | c[I_BNE] | c[I_MULT];
        info.writes_gpr  = wr_rd | wr_rt | c[I_JAL];
        info.dest_idx    = wr_rd ? rd : wr_rt ? rt : c[I_JAL] ? `LINK_REG : '0;
        info.late_result = c[I_LW] | c[I_JAL]; // value not ready before wb
        info.writes_hilo = c[I_MULT];
        info.reads_hi    = c[I_MFHI];
        info.reads_lo    = c[I_MFLO];
        info.rs_idx      = rs;
        info.rt_idx      = rt;
    end

endmodule

/* source/mips_ctrl_cfg.svh */
`ifndef MIPS_CTRL_CFG_SVH
`define MIPS_CTRL_CFG_SVH

`define INSTR_W   32
`define REG_IDX_W 5

// field positions in the instruction word
`define F_OP   31:26
`define F_RS   25:21
`define F_RT   20:16
`define F_RD   15:11
`define F_FUNC 5:0

// opcodes
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// function codes, op == OP_RTYPE
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_JR   6'b001000
`define FN_MFHI 6'b010000
`define FN_MFLO 6'b010010
`define FN_MULT 6'b011000
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

`define LINK_REG 5'd31
`define NOP_WORD 32'h0000_0000

`endif

/* source/mips_ctrl_pkg.sv */
`include "mips_ctrl_cfg.svh"

package mips_ctrl_pkg;

    // bit positions of the one-hot class vector
    typedef enum logic [5:0] {
        I_ADD, I_ADDU, I_SUB, I_SUBU, I_AND, I_OR, I_XOR, I_NOR, I_SLT, I_SLTU,
        I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV, I_JR, I_MULT, I_MFHI, I_MFLO,
        I_ADDI, I_ADDIU, I_ANDI, I_ORI, I_XORI, I_LUI, I_SLTI, I_SLTIU,
        I_LW, I_SW, I_BEQ, I_BNE, I_J, I_JAL,
        I_NUM
    } instr_e;

    typedef struct packed {
        logic [I_NUM-1:0]      cls;        // all zero for nop or unknown
        logic                  reads_rs;
        logic                  reads_rt;
        logic                  writes_gpr;
        logic [`REG_IDX_W-1:0] dest_idx;
        logic                  late_result; // lw, jal
        logic                  writes_hilo;
        logic                  reads_hi;
        logic                  reads_lo;
        logic [`REG_IDX_W-1:0] rs_idx;
        logic [`REG_IDX_W-1:0] rt_idx;
    } instr_info_t;

    typedef enum logic [3:0] {
        ALU_ADDU = 4'b0000, ALU_SUBU = 4'b0001, ALU_ADD = 4'b0010, ALU_SUB = 4'b0011,
        ALU_AND  = 4'b0100, ALU_OR   = 4'b0101, ALU_XOR = 4'b0110, ALU_NOR = 4'b0111,
        ALU_LUI  = 4'b1000, ALU_SLTU = 4'b1010, ALU_SLT = 4'b1011,
        ALU_SRA  = 4'b1100, ALU_SRL  = 4'b1101, ALU_SLL = 4'b1110,
        ALU_PASS = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_SEQ = 2'b00, PC_BRANCH = 2'b01, PC_JUMP = 2'b10, PC_JREG = 2'b11
    } pc_sel_t;

    typedef enum logic [2:0] {
        ALUA_SHAMT = 3'b000, ALUA_RS = 3'b001, ALUA_NPC = 3'b010,
        ALUA_HI    = 3'b011, ALUA_LO = 3'b100
    } alua_sel_t;

    typedef enum logic [1:0] {
        ALUB_RT = 2'b00, ALUB_SEXT_IMM = 2'b01, ALUB_ZEXT_IMM = 2'b10, ALUB_ZERO = 2'b11
    } alub_sel_t;

    typedef enum logic [1:0] {
        RDC_RD = 2'b00, RDC_RT = 2'b01, RDC_LINK = 2'b10
    } rdc_sel_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, FWD_FROM_EX = 2'b01, FWD_FROM_ME = 2'b10, FWD_FROM_WB = 2'b11
    } fwd_sel_t;

endpackage

/* source/pipeline_controller.sv */
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module pipeline_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`INSTR_W-1:0]      if_instr,
    input  logic                     equal,      // rs == rt from datapath
    output logic                     rf_w,
    output mips_ctrl_pkg::alu_op_t   aluc,
    output mips_ctrl_pkg::pc_sel_t   pc_sel,
    output mips_ctrl_pkg::alua_sel_t alua_sel,
    output mips_ctrl_pkg::alub_sel_t alub_sel,
    output logic                     rd_from_mem,
    output mips_ctrl_pkg::rdc_sel_t  rdc_sel,
    output logic                     cs,
    output logic                     dm_r,
    output logic                     dm_w,
    output logic                     hilo_w,
    output logic                     stall,      // fetch holds if_instr
    output mips_ctrl_pkg::fwd_sel_t  rs_fwd,
    output mips_ctrl_pkg::fwd_sel_t  rt_fwd,
    output mips_ctrl_pkg::fwd_sel_t  hi_fwd,
    output mips_ctrl_pkg::fwd_sel_t  lo_fwd
);
    import mips_ctrl_pkg::*;

    logic [`INSTR_W-1:0] id_instr;
    logic [`INSTR_W-1:0] ex_instr;
    logic [`INSTR_W-1:0] me_instr;
    logic [`INSTR_W-1:0] wb_instr;
    instr_info_t         id_info;
    instr_info_t         ex_info;
    instr_info_t         me_info;
    instr_info_t         wb_info;

    stage_pipe u_pipe (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .if_instr (if_instr),
        .id_instr (id_instr),
        .ex_instr (ex_instr),
        .me_instr (me_instr),
        .wb_instr (wb_instr)
    );

    instr_decoder u_dec_id (.instr(id_instr), .info(id_info));
    instr_decoder u_dec_ex (.instr(ex_instr), .info(ex_info));
    instr_decoder u_dec_me (.instr(me_instr), .info(me_info));
    instr_decoder u_dec_wb (.instr(wb_instr), .info(wb_info));

    id_control u_ctrl (
        .id_info     (id_info),
        .equal       (equal),
        .stall       (stall),
        .rf_w        (rf_w),
        .aluc        (aluc),
        .pc_sel      (pc_sel),
        .alua_sel    (alua_sel),
        .alub_sel    (alub_sel),
        .rd_from_mem (rd_from_mem),
        .rdc_sel     (rdc_sel),
        .cs          (cs),
        .dm_r        (dm_r),
        .dm_w        (dm_w),
        .hilo_w      (hilo_w)
    );

    hazard_unit u_hazard (
        .id_info (id_info),
        .ex_info (ex_info),
        .me_info (me_info),
        .wb_info (wb_info),
        .stall   (stall),
        .rs_fwd  (rs_fwd),
        .rt_fwd  (rt_fwd),
        .hi_fwd  (hi_fwd),
        .lo_fwd  (lo_fwd)
    );

endmodule

/* source/stage_pipe.sv */
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module stage_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic [`INSTR_W-1:0] if_instr,
    output logic [`INSTR_W-1:0] id_instr,
    output logic [`INSTR_W-1:0] ex_instr,
    output logic [`INSTR_W-1:0] me_instr,
    output logic [`INSTR_W-1:0] wb_instr
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            id_instr <= `NOP_WORD;
            ex_instr <= `NOP_WORD;
            me_instr <= `NOP_WORD;
            wb_instr <= `NOP_WORD;
        end
        else
        begin
            // back half always drains
            me_instr <= ex_instr;
            wb_instr <= me_instr;
            if (stall)
            begin
                ex_instr <= `NOP_WORD; // bubble, id holds
            end
            else
            begin
                id_instr <= if_instr;
                ex_instr <= id_instr;
            end
        end
    end

endmodule

/* sources.f */
+incdir+source
source/mips_ctrl_pkg.sv
source/instr_decoder.sv
source/stage_pipe.sv
source/id_control.sv
source/hazard_unit.sv
source/pipeline_controller.sv
tests/controller_checker.sv
tests/controller_tb.sv

/* tests/controller_checker.sv */
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module controller_checker (
    input logic                    clk,
    input logic                    rst,
    input logic [`INSTR_W-1:0]     id_instr,
    input logic                    stall,
    input logic                    cs,
    input logic                    dm_w,
    input logic                    rf_w,
    input mips_ctrl_pkg::fwd_sel_t rs_fwd,
    input mips_ctrl_pkg::fwd_sel_t rt_fwd,
    input mips_ctrl_pkg::fwd_sel_t hi_fwd,
    input mips_ctrl_pkg::fwd_sel_t lo_fwd
);
    import mips_ctrl_pkg::*;

    int fail_cnt = 0; // failed assertion count

    // every stage holds a nop after reset
    stall_after_reset: assert property (@(posedge clk) rst |=> !stall)
        else
        begin
            $error("stall high in the cycle after reset");
            fail_cnt++;
        end

    bubble_on_stall: assert property (@(posedge clk) disable iff (rst)
            stall |-> !(cs || dm_w || rf_w))
        else
        begin
            $error("write control high while stalled");
            fail_cnt++;
        end

    nop_no_forward: assert property (@(posedge clk) disable iff (rst)
            (id_instr == `NOP_WORD) |-> (rs_fwd == FWD_NONE && rt_fwd == FWD_NONE
                                         && hi_fwd == FWD_NONE && lo_fwd == FWD_NONE))
        else
        begin
            $error("forwarding select active for a nop in decode");
            fail_cnt++;
        end

endmodule

bind pipeline_controller controller_checker u_chk (
    .clk      (clk),
    .rst      (rst),
    .id_instr (id_instr),
    .stall    (stall),
    .cs       (cs),
    .dm_w     (dm_w),
    .rf_w     (rf_w),
    .rs_fwd   (rs_fwd),
    .rt_fwd   (rt_fwd),
    .hi_fwd   (hi_fwd),
    .lo_fwd   (lo_fwd)
);

/* tests/controller_tb.sv */
`timescale 1ns/1ps
`include "mips_ctrl_cfg.svh"

module controller_tb;
    import mips_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    // reset check, solo decode, branch, gpr fwd, late stall, hi/lo fwd
    localparam int TEST_CYCLES  = 1 + 34 * 4 + 22 + 37 + 40 + 36;

    logic                clk;
    logic                rst;
    logic [`INSTR_W-1:0] if_instr;
    logic                equal;
    logic                rf_w;
    alu_op_t             aluc;
    pc_sel_t             pc_sel;
    alua_sel_t           alua_sel;
    alub_sel_t           alub_sel;
    logic                rd_from_mem;
    rdc_sel_t            rdc_sel;
    logic                cs;
    logic                dm_r;
    logic                dm_w;
    logic                hilo_w;
    logic                stall;
    fwd_sel_t            rs_fwd;
    fwd_sel_t            rt_fwd;
    fwd_sel_t            hi_fwd;
    fwd_sel_t            lo_fwd;
    logic [31:0]         seed = 32'h812a_f5be;

    pipeline_controller uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #((RESET_CYCLES + 2 * TEST_CYCLES) * CLK_PERIOD);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired, the tests did not finish in time");
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [`REG_IDX_W-1:0] rand_reg(); // 1..31
        logic [31:0] r;
        r = next_rand();
        return `REG_IDX_W'((r >> 8) % 31) + 1'b1;
    endfunction

    // shamt 2 keeps every r-type word nonzero
    function automatic logic [`INSTR_W-1:0] r_word(input logic [5:0] func,
            input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
        return {`OP_RTYPE, rs, rt, rd, 5'd2, func};
    endfunction

    function automatic logic [`INSTR_W-1:0] i_word(input logic [5:0] op,
            input logic [4:0] rs, input logic [4:0] rt);
        return {op, rs, rt, 16'h0044};
    endfunction

    function automatic logic [`INSTR_W-1:0] j_word(input logic [5:0] op);
        return {op, 26'h000_0100};
    endfunction

    task automatic report_error(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first failing check");
    endtask

    // word enters id on the next rising edge, returns on the falling edge after it
    task automatic push_word(input logic [`INSTR_W-1:0] w);
        if_instr = w;
        @(negedge clk);
    endtask

    task automatic drain();
        repeat (3) push_word(`NOP_WORD);
    endtask

    task automatic check_fwd(input fwd_sel_t e_rs, input fwd_sel_t e_rt, input string what);
        assert (rs_fwd == e_rs && rt_fwd == e_rt && !stall)
            else report_error($sformatf("%s: rs_fwd %s rt_fwd %s stall %b, expected %s %s",
                what, rs_fwd.name(), rt_fwd.name(), stall, e_rs.name(), e_rt.name()));
    endtask

    task automatic count_stall(input int expected, input string what);
        int cycles;
        cycles = 0;
        if_instr = `NOP_WORD; // next fetch word, held while stalled
        while (stall && cycles <= expected)
        begin
            assert (!(rf_w | cs | dm_r | dm_w | hilo_w))
                else report_error($sformatf("%s: write control high during stall", what));
            cycles++;
            @(negedge clk);
        end
        assert (cycles == expected)
            else report_error($sformatf("%s: %0d stall cycles, expected %0d",
                what, cycles, expected));
    endtask

    task automatic reset_state_check();
        assert (!(rf_w | cs | dm_r | dm_w | hilo_w | stall) && pc_sel == PC_SEQ)
            else report_error("write controls, stall or pc_sel not idle after reset");
        assert (hi_fwd == FWD_NONE && lo_fwd == FWD_NONE)
            else report_error("hi/lo forwarding active after reset");
        check_fwd(FWD_NONE, FWD_NONE, "after reset");
    endtask

    // e_flags is {rd_from_mem, cs, dm_r, dm_w, rf_w, hilo_w}
    task automatic check_solo(input logic [`INSTR_W-1:0] w, input alu_op_t e_aluc,
            input alua_sel_t e_a, input alub_sel_t e_b, input rdc_sel_t e_rdc,
            input logic [5:0] e_flags);
        logic [5:0] flags;
        push_word(w);
        flags = {rd_from_mem, cs, dm_r, dm_w, rf_w, hilo_w};
        assert (aluc == e_aluc && alua_sel == e_a && alub_sel == e_b && rdc_sel == e_rdc)
            else report_error($sformatf("instr %h: aluc %b alua %b alub %b rdc %b",
                w, aluc, alua_sel, alub_sel, rdc_sel));
        assert (flags == e_flags && !stall)
            else report_error($sformatf("instr %h: flags %b stall %b, expected %b",
                w, flags, stall, e_flags));
        drain();
    endtask

    task automatic decode_each_instr();
        check_solo(r_word(`FN_ADD, 1, 2, 3), ALU_ADD, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_ADDU, 1, 2, 3), ALU_ADDU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SUB, 1, 2, 3), ALU_SUB, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SUBU, 1, 2, 3), ALU_SUBU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_AND, 1, 2, 3), ALU_AND, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_OR, 1, 2, 3), ALU_OR, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_XOR, 1, 2, 3), ALU_XOR, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_NOR, 1, 2, 3), ALU_NOR, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SLT, 1, 2, 3), ALU_SLT, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SLTU, 1, 2, 3), ALU_SLTU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SLL, 1, 2, 3), ALU_SLL, ALUA_SHAMT, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SRL, 1, 2, 3), ALU_SRL, ALUA_SHAMT, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SRA, 1, 2, 3), ALU_SRA, ALUA_SHAMT, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SLLV, 1, 2, 3), ALU_SLL, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SRLV, 1, 2, 3), ALU_SRL, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_SRAV, 1, 2, 3), ALU_SRA, ALUA_RS, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_JR, 1, 0, 0), ALU_ADDU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000000);
        check_solo(r_word(`FN_MULT, 1, 2, 0), ALU_ADDU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000001);
        check_solo(r_word(`FN_MFHI, 0, 0, 3), ALU_PASS, ALUA_HI, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(r_word(`FN_MFLO, 0, 0, 3), ALU_PASS, ALUA_LO, ALUB_RT, RDC_RD, 6'b000010);
        check_solo(i_word(`OP_ADDI, 1, 2), ALU_ADD, ALUA_RS, ALUB_SEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_ADDIU, 1, 2), ALU_ADDU, ALUA_RS, ALUB_SEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_ANDI, 1, 2), ALU_AND, ALUA_RS, ALUB_ZEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_ORI, 1, 2), ALU_OR, ALUA_RS, ALUB_ZEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_XORI, 1, 2), ALU_XOR, ALUA_RS, ALUB_ZEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_LUI, 0, 2), ALU_LUI, ALUA_RS, ALUB_ZEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_SLTI, 1, 2), ALU_SLT, ALUA_RS, ALUB_SEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_SLTIU, 1, 2), ALU_SLTU, ALUA_RS, ALUB_SEXT_IMM, RDC_RT, 6'b000010);
        check_solo(i_word(`OP_LW, 1, 2), ALU_ADD, ALUA_RS, ALUB_SEXT_IMM, RDC_RT, 6'b111010);
        check_solo(i_word(`OP_SW, 1, 2), ALU_ADD, ALUA_RS, ALUB_SEXT_IMM, RDC_RD, 6'b010100);
        check_solo(i_word(`OP_BEQ, 1, 2), ALU_ADDU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000000);
        check_solo(i_word(`OP_BNE, 1, 2), ALU_ADDU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000000);
        check_solo(j_word(`OP_J), ALU_ADDU, ALUA_RS, ALUB_RT, RDC_RD, 6'b000000);
        check_solo(j_word(`OP_JAL), ALU_ADDU, ALUA_NPC, ALUB_ZERO, RDC_LINK, 6'b000010);
    endtask

    task automatic branch_and_jump();
        logic [31:0] r;
        logic        eq;
        for (int i = 0; i < 8; i++)
        begin
            r  = next_rand();
            eq = r[12];
            equal = eq;
            push_word(i_word(`OP_BEQ, 1, 2));
            assert (pc_sel == (eq ? PC_BRANCH : PC_SEQ))
                else report_error($sformatf("beq with equal %b: pc_sel %b", eq, pc_sel));
            push_word(i_word(`OP_BNE, 1, 2));
            assert (pc_sel == (eq ? PC_SEQ : PC_BRANCH))
                else report_error($sformatf("bne with equal %b: pc_sel %b", eq, pc_sel));
        end
        equal = 1'b0;
        push_word(j_word(`OP_J));
        assert (pc_sel == PC_JUMP) else report_error($sformatf("j: pc_sel %b", pc_sel));
        push_word(j_word(`OP_JAL));
        assert (pc_sel == PC_JUMP) else report_error($sformatf("jal: pc_sel %b", pc_sel));
        push_word(r_word(`FN_JR, 5, 0, 0));
        assert (pc_sel == PC_JREG) else report_error($sformatf("jr: pc_sel %b", pc_sel));
        drain();
    endtask

    task automatic gpr_forward_distance();
        logic [`REG_IDX_W-1:0] r;
        fwd_sel_t              want;
        for (int n = 0; n < 4; n++)
        begin
            r    = rand_reg();
            want = (n == 0) ? FWD_FROM_EX : (n == 1) ? FWD_FROM_ME
                 : (n == 2) ? FWD_FROM_WB : FWD_NONE;
            push_word(r_word(`FN_ADD, 0, 0, r));
            repeat (n) push_word(`NOP_WORD);
            push_word(r_word(`FN_SUB, r, r, 0));
            check_fwd(want, want, $sformatf("writer %0d ahead on r%0d", n + 1, r));
            drain();
        end
        r = rand_reg();
        push_word(r_word(`FN_ADD, 0, 0, r));
        push_word(i_word(`OP_ORI, 0, r)); // nearer writer
        push_word(r_word(`FN_SUB, r, r, 0));
        check_fwd(FWD_FROM_EX, FWD_FROM_EX, "two writers");
        drain();
        push_word(r_word(`FN_ADD, 1, 2, 0));
        push_word(r_word(`FN_SUB, 0, 0, 0));
        check_fwd(FWD_NONE, FWD_NONE, "writer to r0");
        drain();
    endtask

    task automatic late_result_stall();
        logic [`REG_IDX_W-1:0] r;
        logic [`INSTR_W-1:0]   reader [4];
        r         = rand_reg();
        reader[0] = r_word(`FN_ADD, r, 0, 0);
        reader[1] = i_word(`OP_LW, r, 0);   // load address from the load
        reader[2] = i_word(`OP_SW, 0, r);   // store data from the load
        reader[3] = r_word(`FN_MULT, r, 0, 0);
        for (int i = 0; i < 4; i++)
        begin
            push_word(i_word(`OP_LW, 0, r));
            push_word(reader[i]);
            count_stall(3, $sformatf("lw then %h", reader[i]));
            check_fwd(FWD_NONE, FWD_NONE, $sformatf("%h after lw", reader[i]));
            drain();
        end
        push_word(j_word(`OP_JAL));
        push_word(r_word(`FN_JR, `LINK_REG, 0, 0));
        count_stall(3, "jal then jr");
        assert (pc_sel == PC_JREG) else report_error("jr after jal: pc_sel not JREG");
        check_fwd(FWD_NONE, FWD_NONE, "jr after jal");
        drain();
    endtask

    task automatic hilo_forward_distance();
        fwd_sel_t want;
        for (int k = 0; k < 2; k++)
        begin
            for (int n = 0; n < 3; n++)
            begin
                want = (n == 0) ? FWD_FROM_EX : (n == 1) ? FWD_FROM_ME : FWD_FROM_WB;
                push_word(r_word(`FN_MULT, 1, 2, 0));
                repeat (n) push_word(`NOP_WORD);
                push_word(r_word(k ? `FN_MFLO : `FN_MFHI, 0, 0, 3));
                assert (hi_fwd == (k ? FWD_NONE : want) && lo_fwd == (k ? want : FWD_NONE)
                        && !stall)
                    else report_error($sformatf("mult %0d ahead: hi_fwd %s lo_fwd %s stall %b",
                        n + 1, hi_fwd.name(), lo_fwd.name(), stall));
                drain();
            end
        end
    endtask

    initial
    begin
        rst      = 1'b1;
        if_instr = `NOP_WORD;
        equal    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state_check();
        decode_each_instr();
        branch_and_jump();
        gpr_forward_distance();
        late_result_stall();
        hilo_forward_distance();

        if (uut.u_chk.fail_cnt == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** FAILED ***");
            $fatal(1, "%0d concurrent assertion failures", uut.u_chk.fail_cnt);
        end
    end

endmodule
